//--- hdl/cam_link_pkg.sv
package cam_link_pkg;

    localparam int unsigned count_width = 8;
    localparam logic [31:0] rate_window_cycles = 32'd84_000_000; // one second at board clock
    localparam int unsigned sync_stages = 2;

    // done flags coming from other clock domains
    typedef struct packed {
        logic mac_init_done;
        logic cam_init_done;
        logic calib_done;     // ddr3 calibration complete
    } status_t;

    // single cycle pulses in the cam_port domain
    typedef struct packed {
        logic vsync_rise;
        logic jpeg_done_rise;
    } event_t;

    // active high reset releases, one per downstream block
    typedef struct packed {
        logic ddr3;
        logic mac;
        logic cam;
        logic ddr3_master;
        logic jpeg;
    } rst_release_t;

    // one open pin as seen by the board wrapper
    typedef struct packed {
        logic out;
        logic out_en;
    } bus_drive_t;

    typedef enum logic {
        owner_mac = 1'b0,
        owner_cam = 1'b1
    } bus_owner_t;

    typedef logic [count_width-1:0] count_t;

    typedef struct packed {
        count_t frame_count;
        count_t jpeg_count;
    } rate_report_t;

    typedef logic [3:0] step_led_t;

    localparam step_led_t step_led_init = 4'b1111; // leds are active low on the board

endpackage

//--- hdl/status_capture.sv
`timescale 1ns/1ps

module status_capture (
    input  logic                  cam_port,
    input  logic                  rst_n,
    input  cam_link_pkg::status_t i_status,
    input  logic                  i_vsync,
    input  logic                  i_jpeg_done,
    output cam_link_pkg::status_t o_status,
    output cam_link_pkg::event_t  o_event
);

    import cam_link_pkg::*;

    status_t sync_q [sync_stages];

    logic   vsync_d;     // previous vsync sample
    logic   jpeg_done_d;
    event_t event_q;

    // flag synchronizer, one status_t per stage
    always_ff @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < sync_stages; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= i_status;
            for (int i = 1; i < sync_stages; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign o_status = sync_q[sync_stages-1];

    // rising edge detect, registered so the pulse lasts exactly one cycle
    always_ff @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            vsync_d     <= 1'b0;
            jpeg_done_d <= 1'b0;
            event_q     <= '0;
        end else begin
            vsync_d                <= i_vsync;
            jpeg_done_d            <= i_jpeg_done;
            event_q.vsync_rise     <= i_vsync & ~vsync_d;
            event_q.jpeg_done_rise <= i_jpeg_done & ~jpeg_done_d;
        end
    end

    assign o_event = event_q;

endmodule

//--- hdl/bring_up_sequencer.sv
`timescale 1ns/1ps

module bring_up_sequencer (
    input  logic                       cam_port,
    input  logic                       rst_n,
    input  cam_link_pkg::status_t      i_status,
    output cam_link_pkg::rst_release_t o_rst_release,
    output cam_link_pkg::bus_owner_t   o_bus_owner,
    output cam_link_pkg::step_led_t    o_step_led
);

    import cam_link_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_mac_init,
        st_cam_init,
        st_wait_all,
        st_running
    } state_t;

    state_t    state_q;
    state_t    state_d;
    step_led_t step_led_q;
    logic      all_done;
    logic      step;     // any state transition

    assign all_done = i_status.mac_init_done & i_status.cam_init_done & i_status.calib_done;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                state_d = st_mac_init; // nothing to wait for
            end
            st_mac_init: begin
                if (i_status.mac_init_done) begin
                    state_d = st_cam_init;
                end
            end
            st_cam_init: begin
                if (i_status.cam_init_done) begin
                    state_d = st_wait_all;
                end
            end
            st_wait_all: begin
                if (all_done) begin
                    state_d = st_running;
                end
            end
            st_running: begin
                state_d = st_running;  // final
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    assign step = (state_d != state_q);

    always_ff @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= st_idle;
            step_led_q <= step_led_init;
        end else begin
            state_q <= state_d;
            if (step) begin
                step_led_q <= step_led_q << 1; // progress bar, zero fill
            end
        end
    end

    // reset releases straight from the state register
    always_comb begin
        o_rst_release             = '0;
        o_rst_release.ddr3        = (state_q != st_idle);
        o_rst_release.mac         = (state_q != st_idle);
        o_rst_release.cam         = (state_q == st_cam_init) || (state_q == st_wait_all)
                                    || (state_q == st_running);
        o_rst_release.ddr3_master = (state_q == st_running);
        o_rst_release.jpeg        = (state_q == st_running);
    end

    // camera takes the shared pins as soon as its reset is released
    assign o_bus_owner = o_rst_release.cam ? owner_cam : owner_mac;
    assign o_step_led  = step_led_q;

endmodule

//--- hdl/rate_monitor.sv
`timescale 1ns/1ps

module rate_monitor #(
    parameter logic [31:0] window_cycles = cam_link_pkg::rate_window_cycles
) (
    input  logic                       cam_port,
    input  logic                       rst_n,
    input  cam_link_pkg::event_t       i_event,
    output cam_link_pkg::rate_report_t o_rate,
    output logic                       o_rate_valid,
    output logic                       o_frame_led,
    output logic                       o_jpeg_led
);

    import cam_link_pkg::*;

    logic [31:0]  win_q;
    logic         win_end;
    count_t       frame_q;
    count_t       jpeg_q;
    count_t       frame_next;    // count including this cycle's pulse
    count_t       jpeg_next;
    rate_report_t rate_q;

    assign win_end    = (win_q == window_cycles - 32'd1);
    assign frame_next = frame_q + count_t'(i_event.vsync_rise);
    assign jpeg_next  = jpeg_q + count_t'(i_event.jpeg_done_rise);

    always_ff @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            win_q        <= '0;
            frame_q      <= '0;
            jpeg_q       <= '0;
            o_rate_valid <= 1'b0;
            o_frame_led  <= 1'b0;
            o_jpeg_led   <= 1'b0;
        end else begin
            o_rate_valid <= win_end;
            if (win_end) begin
                win_q   <= '0;
                frame_q <= '0;
                jpeg_q  <= '0;
            end else begin
                win_q   <= win_q + 32'd1;
                frame_q <= frame_next; // wraps at 8 bits
                jpeg_q  <= jpeg_next;
            end
            o_frame_led <= o_frame_led ^ i_event.vsync_rise;
            o_jpeg_led  <= o_jpeg_led ^ i_event.jpeg_done_rise;
        end
    end

    // report register, only meaningful while o_rate_valid is high
    always_ff @(posedge cam_port) begin
        if (win_end) begin
            rate_q.frame_count <= frame_next;
            rate_q.jpeg_count  <= jpeg_next;
        end
    end

    assign o_rate = rate_q;

endmodule

//--- hdl/serial_bus_mux.sv
`timescale 1ns/1ps

module serial_bus_mux (
    input  cam_link_pkg::bus_owner_t i_bus_owner,
    input  cam_link_pkg::bus_drive_t i_mac_mdc,
    input  cam_link_pkg::bus_drive_t i_mac_mdio,
    input  cam_link_pkg::bus_drive_t i_cam_scl,
    input  cam_link_pkg::bus_drive_t i_cam_sda,
    output cam_link_pkg::bus_drive_t o_scl_mdc,
    output cam_link_pkg::bus_drive_t o_sda_mdio
);

    import cam_link_pkg::*;

    always_comb begin
        case (i_bus_owner)
            owner_cam: begin
                o_scl_mdc  = i_cam_scl;   // i2c clock may be stretched, keep its enable
                o_sda_mdio = i_cam_sda;
            end
            default: begin
                o_scl_mdc.out    = i_mac_mdc.out;
                o_scl_mdc.out_en = 1'b1;  // mdc is always driven by the mac
                o_sda_mdio       = i_mac_mdio;
            end
        endcase
    end

endmodule

//--- hdl/cam_link_top.sv
`timescale 1ns/1ps

module cam_link_top #(
    parameter logic [31:0] window_cycles = cam_link_pkg::rate_window_cycles
) (
    input  logic                       cam_port,
    input  logic                       rst_n,

    input  cam_link_pkg::status_t      i_status,     // async done flags
    input  logic                       i_vsync,
    input  logic                       i_jpeg_done,

    input  cam_link_pkg::bus_drive_t   i_mac_mdc,
    input  cam_link_pkg::bus_drive_t   i_mac_mdio,
    input  cam_link_pkg::bus_drive_t   i_cam_scl,
    input  cam_link_pkg::bus_drive_t   i_cam_sda,
    output cam_link_pkg::bus_drive_t   o_scl_mdc,
    output cam_link_pkg::bus_drive_t   o_sda_mdio,

    output cam_link_pkg::rst_release_t o_rst_release,
    output cam_link_pkg::step_led_t    o_step_led,
    output logic                       o_frame_led,
    output logic                       o_jpeg_led,
    output cam_link_pkg::rate_report_t o_rate,
    output logic                       o_rate_valid
);

    import cam_link_pkg::*;

    status_t    status_sync;
    event_t     event_pulse;
    bus_owner_t bus_owner;

    status_capture status_capture_i (
        .cam_port    (cam_port),
        .rst_n       (rst_n),
        .i_status    (i_status),
        .i_vsync     (i_vsync),
        .i_jpeg_done (i_jpeg_done),
        .o_status    (status_sync),
        .o_event     (event_pulse)
    );

    bring_up_sequencer bring_up_sequencer_i (
        .cam_port      (cam_port),
        .rst_n         (rst_n),
        .i_status      (status_sync),
        .o_rst_release (o_rst_release),
        .o_bus_owner   (bus_owner),
        .o_step_led    (o_step_led)
    );

    rate_monitor #(
        .window_cycles (window_cycles)
    ) rate_monitor_i (
        .cam_port     (cam_port),
        .rst_n        (rst_n),
        .i_event      (event_pulse),
        .o_rate       (o_rate),
        .o_rate_valid (o_rate_valid),
        .o_frame_led  (o_frame_led),
        .o_jpeg_led   (o_jpeg_led)
    );

    serial_bus_mux serial_bus_mux_i (
        .i_bus_owner (bus_owner),
        .i_mac_mdc   (i_mac_mdc),
        .i_mac_mdio  (i_mac_mdio),
        .i_cam_scl   (i_cam_scl),
        .i_cam_sda   (i_cam_sda),
        .o_scl_mdc   (o_scl_mdc),
        .o_sda_mdio  (o_sda_mdio)
    );

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 4,
    parameter int reset_cycles = 5
) (
    output logic cam_port,
    output logic rst_n
);

    initial begin
        cam_port = 1'b0;
        forever #(period_ns / 2) cam_port = ~cam_port;
    end

    // reset held low over the first few rising edges
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge cam_port);
        rst_n <= 1'b1;
    end

endmodule

//--- verif/cam_link_assert.sv
`timescale 1ns/1ps

module cam_link_assert (
    input logic                       i_cam_port,
    input logic                       i_rst_n,
    input cam_link_pkg::bus_owner_t   i_bus_owner,
    input cam_link_pkg::bus_drive_t   i_scl_mdc,
    input cam_link_pkg::rst_release_t i_rst_release,
    input logic                       i_rate_valid
);

    import cam_link_pkg::*;

    int fail_count = 0; // failed assertion evaluations

    // mac drives mdc continuously while it owns the pins
    mdc_enable_forced: assert property (
        @(posedge i_cam_port) disable iff (!i_rst_n)
        (i_bus_owner == owner_mac) |-> i_scl_mdc.out_en
    ) else begin
        fail_count++;
        $error("mdc enable low while the mac owns the shared pins");
    end

    // a released block never goes back into reset
    release_sticky: assert property (
        @(posedge i_cam_port) disable iff (!i_rst_n)
        ($past(i_rst_release) & ~i_rst_release) == 5'b0
    ) else begin
        fail_count++;
        $error("reset release bit dropped without a reset");
    end

    rate_valid_single: assert property (
        @(posedge i_cam_port) disable iff (!i_rst_n)
        i_rate_valid |=> !i_rate_valid
    ) else begin
        fail_count++;
        $error("rate valid high on two consecutive cycles");
    end

endmodule

bind cam_link_top cam_link_assert cam_link_assert_i (
    .i_cam_port    (cam_port),
    .i_rst_n       (rst_n),
    .i_bus_owner   (bus_owner),
    .i_scl_mdc     (o_scl_mdc),
    .i_rst_release (o_rst_release),
    .i_rate_valid  (o_rate_valid)
);

//--- verif/cam_link_tb.sv
`timescale 1ns/1ps

module cam_link_tb;

    import cam_link_pkg::*;

    localparam int window_cycles = 64;
    localparam int num_windows   = 10;
    localparam int settle_bound  = 12;  // sync depth plus a state step, with slack
    localparam int period_ns     = 4;
    localparam int reset_cycles  = 5;
    localparam int watchdog_ns   =
        (reset_cycles + 4 * settle_bound + num_windows * window_cycles + 50) * period_ns;

    typedef struct packed {
        bus_drive_t scl;
        bus_drive_t sda;
    } pin_pair_t;

    logic         cam_port;
    logic         rst_n;
    status_t      i_status;
    logic         i_vsync;
    logic         i_jpeg_done;
    bus_drive_t   i_mac_mdc;
    bus_drive_t   i_mac_mdio;
    bus_drive_t   i_cam_scl;
    bus_drive_t   i_cam_sda;
    bus_drive_t   o_scl_mdc;
    bus_drive_t   o_sda_mdio;
    rst_release_t o_rst_release;
    step_led_t    o_step_led;
    logic         o_frame_led;
    logic         o_jpeg_led;
    rate_report_t o_rate;
    logic         o_rate_valid;

    int      errors = 0;
    int      cycle = 0;        // rising edges since reset release
    int      reports = 0;
    int      last_report = 0;
    int      frame_total = 0;  // edges already reported
    int      jpeg_total = 0;
    status_t applied;          // flags driven so far
    int      frame_tally [0:num_windows+2];
    int      jpeg_tally [0:num_windows+2];

    tb_clock_gen #(
        .period_ns    (period_ns),
        .reset_cycles (reset_cycles)
    ) tb_clock_gen_i (
        .cam_port (cam_port),
        .rst_n    (rst_n)
    );

    cam_link_top #(
        .window_cycles (window_cycles)
    ) cam_link_top_i (
        .cam_port      (cam_port),
        .rst_n         (rst_n),
        .i_status      (i_status),
        .i_vsync       (i_vsync),
        .i_jpeg_done   (i_jpeg_done),
        .i_mac_mdc     (i_mac_mdc),
        .i_mac_mdio    (i_mac_mdio),
        .i_cam_scl     (i_cam_scl),
        .i_cam_sda     (i_cam_sda),
        .o_scl_mdc     (o_scl_mdc),
        .o_sda_mdio    (o_sda_mdio),
        .o_rst_release (o_rst_release),
        .o_step_led    (o_step_led),
        .o_frame_led   (o_frame_led),
        .o_jpeg_led    (o_jpeg_led),
        .o_rate        (o_rate),
        .o_rate_valid  (o_rate_valid)
    );

    function automatic pin_pair_t expected_pins(input logic cam_rel, input bus_drive_t mdc,
                                                input bus_drive_t mdio, input bus_drive_t scl,
                                                input bus_drive_t sda);
        pin_pair_t p;
        if (cam_rel) begin
            p.scl = scl;
            p.sda = sda;
        end else begin
            p.scl.out    = mdc.out;
            p.scl.out_en = 1'b1;  // mdc always driven
            p.sda        = mdio;
        end
        return p;
    endfunction

    // settled release set once the given flags have been seen
    function automatic rst_release_t expected_release(input status_t f);
        rst_release_t r;
        r.ddr3        = 1'b1;  // idle leaves on its own
        r.mac         = 1'b1;
        r.cam         = f.mac_init_done;
        r.ddr3_master = f.mac_init_done & f.cam_init_done & f.calib_done;
        r.jpeg        = r.ddr3_master;
        return r;
    endfunction

    function automatic step_led_t expected_step_led(input status_t f);
        int shifts;
        shifts = 1;
        if (f.mac_init_done) shifts++;
        if (f.mac_init_done && f.cam_init_done) shifts++;
        if (f.mac_init_done && f.cam_init_done && f.calib_done) shifts++;
        return 4'b1111 << shifts;
    endfunction

    // edge driven at cycle k is registered, then counted two edges later
    function automatic int report_window(input int drive_cycle);
        return (drive_cycle + 1) / window_cycles + 1;
    endfunction

    function automatic count_t expected_count(input int tally);
        return count_t'(tally % 256);
    endfunction

    function automatic logic next_pulse_level(input logic level);
        if (level) begin
            return ($urandom % 2) != 0;  // short pulses
        end
        return ($urandom % 4) == 0;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("Mismatch %s: expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic apply_flags(input status_t f);
        @(posedge cam_port);
        applied = f;
        i_status <= f;
    endtask

    task automatic wait_settled(input string stage);
        rst_release_t exp_rel;
        step_led_t    exp_led;
        int           n;
        exp_rel = expected_release(applied);
        exp_led = expected_step_led(applied);
        n = 0;
        do begin
            @(negedge cam_port);
            n++;
        end while ((o_rst_release !== exp_rel || o_step_led !== exp_led) && n < settle_bound);
        assert (o_rst_release === exp_rel && o_step_led === exp_led) else begin
            errors++;
            $display("%s stage not reached within %0d cycles: release %b, step leds %b",
                     stage, settle_bound, o_rst_release, o_step_led);
        end
    endtask

    // random stimulus, one update per rising edge
    initial begin
        logic vsync_lvl;
        logic jpeg_lvl;
        logic level_next;
        vsync_lvl   = 1'b0;
        jpeg_lvl    = 1'b0;
        i_vsync     = 1'b0;
        i_jpeg_done = 1'b0;
        i_mac_mdc   = '0;
        i_mac_mdio  = '0;
        i_cam_scl   = '0;
        i_cam_sda   = '0;
        for (int i = 0; i <= num_windows + 2; i++) begin
            frame_tally[i] = 0;
            jpeg_tally[i]  = 0;
        end
        void'($urandom(16));
        wait (rst_n === 1'b1);
        forever begin
            @(posedge cam_port);
            cycle++;
            i_mac_mdc  <= 2'($urandom);
            i_mac_mdio <= 2'($urandom);
            i_cam_scl  <= 2'($urandom);
            i_cam_sda  <= 2'($urandom);
            level_next = next_pulse_level(vsync_lvl);
            if (level_next && !vsync_lvl && report_window(cycle) <= num_windows + 2) begin
                frame_tally[report_window(cycle)]++;
            end
            vsync_lvl = level_next;
            i_vsync <= vsync_lvl;
            level_next = next_pulse_level(jpeg_lvl);
            if (level_next && !jpeg_lvl && report_window(cycle) <= num_windows + 2) begin
                jpeg_tally[report_window(cycle)]++;
            end
            jpeg_lvl = level_next;
            i_jpeg_done <= jpeg_lvl;
        end
    end

    // compare on the falling edge where everything is stable
    always @(negedge cam_port) begin
        pin_pair_t    pins_exp;
        rst_release_t rel_allowed;
        int           w;
        pins_exp = expected_pins(o_rst_release.cam, i_mac_mdc, i_mac_mdio, i_cam_scl, i_cam_sda);
        check_eq("scl_mdc", pins_exp.scl, o_scl_mdc);
        check_eq("sda_mdio", pins_exp.sda, o_sda_mdio);
        rel_allowed = expected_release(applied);
        assert ((o_rst_release & ~rel_allowed) == 5'b0) else begin
            errors++;
            $display("reset release %b raised ahead of the done flags", o_rst_release);
        end
        assert (!o_rst_release.cam || (o_rst_release.ddr3 && o_rst_release.mac)) else begin
            errors++;
            $display("camera released before ddr3 and mac");
        end
        if (rst_n) begin
            check_eq("rate_valid", (cycle != 0 && cycle % window_cycles == 0), o_rate_valid);
        end
        if (rst_n && o_rate_valid) begin
            w = cycle / window_cycles;
            check_eq("rate_period", last_report + window_cycles, cycle);
            check_eq("frame_count", expected_count(frame_tally[w]), o_rate.frame_count);
            check_eq("jpeg_count", expected_count(jpeg_tally[w]), o_rate.jpeg_count);
            frame_total += frame_tally[w];
            jpeg_total  += jpeg_tally[w];
            check_eq("frame_led", frame_total % 2, o_frame_led);  // one toggle per edge
            check_eq("jpeg_led", jpeg_total % 2, o_jpeg_led);
            last_report = cycle;
            reports++;
        end
    end

    initial begin
        applied  = '0;
        i_status = '0;
        wait (rst_n === 1'b1);
        @(negedge cam_port);
        check_eq("reset_release", 0, o_rst_release);
        check_eq("reset_step_led", 4'b1111, o_step_led);
        check_eq("reset_rate_valid", 0, o_rate_valid);
        check_eq("reset_frame_led", 0, o_frame_led);
        check_eq("reset_jpeg_led", 0, o_jpeg_led);
        wait_settled("mac_init");
        apply_flags(3'b100);
        wait_settled("cam_init");
        apply_flags(3'b110);
        wait_settled("wait_all");
        apply_flags(3'b111);
        wait_settled("running");
        while (cycle < num_windows * window_cycles + 2) @(negedge cam_port);
        check_eq("report_count", num_windows, reports);
        $display("run complete, check errors %0d, assertion failures %0d",
                 errors, cam_link_top_i.cam_link_assert_i.fail_count);
        if (errors == 0 && cam_link_top_i.cam_link_assert_i.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout after %0d ns, run did not complete", watchdog_ns);
        $display("Errors found");
        $finish;
    end

endmodule

//--- project.f
hdl/cam_link_pkg.sv
hdl/status_capture.sv
hdl/bring_up_sequencer.sv
hdl/rate_monitor.sv
hdl/serial_bus_mux.sv
hdl/cam_link_top.sv
verif/tb_clock_gen.sv
verif/cam_link_assert.sv
verif/cam_link_tb.sv

//--- Bender.yml
package:
  name: cam_link

sources:
  - hdl/cam_link_pkg.sv
  - hdl/status_capture.sv
  - hdl/bring_up_sequencer.sv
  - hdl/rate_monitor.sv
  - hdl/serial_bus_mux.sv
  - hdl/cam_link_top.sv
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/cam_link_assert.sv
      - verif/cam_link_tb.sv
